/* bp_patterns.txt */
# stall pc imme_sign resolve_valid resolve_pc resolve_taken ras_push ras_pop pc_add_4
# check (bit 0 branch, bit 1 jalr) exp_branch exp_jalr, all fields in hex
0 00000100 1 0 00000000 0 0 0 00000000 3 1 00000000
0 00000100 0 0 00000000 0 0 0 00000000 3 0 00000000
0 00000200 1 0 00000000 0 0 0 00000000 3 1 00000000
0 00000100 0 1 00000100 1 0 0 00000000 2 0 00000000
0 00000100 0 1 00000100 1 0 0 00000000 2 0 00000000
0 00000100 0 1 00000100 1 0 0 00000000 2 0 00000000
0 00000100 0 1 00000100 1 0 0 00000000 2 0 00000000
0 00000100 0 1 00000100 1 0 0 00000000 2 0 00000000
0 00000100 0 0 00000000 0 0 0 00000000 3 0 00000000
0 00000100 0 1 00000100 1 0 0 00000000 2 0 00000000
0 00000100 0 1 00000100 1 0 0 00000000 2 0 00000000
0 00000100 0 1 00000100 1 0 0 00000000 2 0 00000000
0 00000100 0 0 00000000 0 0 0 00000000 3 1 00000000
1 00000100 0 1 00000100 0 0 0 00000000 2 0 00000000
1 00000100 0 1 00000100 0 0 0 00000000 2 0 00000000
0 00000100 0 0 00000000 0 0 0 00000000 3 1 00000000
0 00000104 0 1 00000104 1 0 0 00000000 2 0 00000000
0 00000104 0 1 00000104 0 0 0 00000000 2 0 00000000
0 00000104 0 1 00000104 1 0 0 00000000 2 0 00000000
0 00000104 0 1 00000104 0 0 0 00000000 2 0 00000000
0 00000104 0 1 00000104 1 0 0 00000000 2 0 00000000
0 00000104 0 1 00000104 0 0 0 00000000 2 0 00000000
0 00000104 0 1 00000104 1 0 0 00000000 2 0 00000000
0 00000104 0 1 00000104 0 0 0 00000000 2 0 00000000
0 00000104 0 0 00000000 0 0 0 00000000 3 1 00000000
0 00000104 1 1 00000104 1 0 0 00000000 2 0 00000000
0 00000104 1 0 00000000 0 0 0 00000000 3 0 00000000
0 00000104 0 0 00000000 0 1 0 0000a004 3 0 00000000
0 00000104 0 0 00000000 0 1 0 0000a008 3 0 0000a004
0 00000104 0 0 00000000 0 1 0 0000a00c 3 0 0000a008
0 00000104 0 0 00000000 0 1 0 0000a010 3 0 0000a00c
0 00000104 0 0 00000000 0 1 0 0000a014 3 0 0000a010
0 00000104 0 0 00000000 0 1 0 0000a018 3 0 0000a014
0 00000104 0 0 00000000 0 1 0 0000a01c 3 0 0000a018
0 00000104 0 0 00000000 0 1 0 0000a020 3 0 0000a01c
0 00000104 0 0 00000000 0 1 0 0000a024 3 0 0000a020
0 00000104 0 0 00000000 0 0 1 00000000 3 0 0000a024
0 00000104 0 0 00000000 0 0 1 00000000 3 0 0000a020
0 00000104 0 0 00000000 0 0 1 00000000 3 0 0000a01c
0 00000104 0 0 00000000 0 0 1 00000000 3 0 0000a018
0 00000104 0 0 00000000 0 0 1 00000000 3 0 0000a014
0 00000104 0 0 00000000 0 0 1 00000000 3 0 0000a010
0 00000104 0 0 00000000 0 0 1 00000000 3 0 0000a00c
0 00000104 0 0 00000000 0 0 1 00000000 3 0 0000a008
0 00000104 0 0 00000000 0 1 1 0000b004 3 0 0000a024
0 00000104 0 0 00000000 0 0 0 00000000 3 0 0000b004
0 00000104 0 0 00000000 0 0 1 00000000 3 0 0000b004
0 00000104 0 0 00000000 0 0 0 00000000 3 0 0000a020

/* list.f */
bp_pkg.sv
bp_update_if.sv
bp_ctrl.sv
history_predictor.sv
return_stack.sv
branch_predictor.sv
tb_branch_predictor.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_branch_predictor
LOG ?= sim.log
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := bp_pkg.sv bp_update_if.sv bp_ctrl.sv history_predictor.sv \
	return_stack.sv branch_predictor.sv tb_branch_predictor.sv

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): list.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;

	localparam int clk_period = 10;
	localparam int reset_cycles = 8;
	localparam int release_timeout = 20;
	localparam int max_cycles = 200;
	localparam string pattern_file = "bp_patterns.txt";

	logic clk;
	logic rst_n;
	logic stall;
	logic [bp_pkg::pc_width-1:0] pc;
	logic imme_sign;
	logic resolve_valid;
	logic [bp_pkg::pc_width-1:0] resolve_pc;
	logic resolve_taken;
	logic ras_push;
	logic ras_pop;
	logic [bp_pkg::pc_width-1:0] pc_add_4;
	wire branch_prediction_result;
	wire [bp_pkg::pc_width-1:0] jalr_prediction_result;

	// Fields of the current pattern line
	logic stall_v;
	logic [bp_pkg::pc_width-1:0] pc_v;
	logic imme_v;
	logic valid_v;
	logic [bp_pkg::pc_width-1:0] resolve_pc_v;
	logic taken_v;
	logic push_v;
	logic pop_v;
	logic [bp_pkg::pc_width-1:0] pc_add_4_v;
	logic [3:0] chk_v;
	logic exp_branch_v;
	logic [bp_pkg::pc_width-1:0] exp_jalr_v;

	int value_errors;
	int format_errors;
	int timeout_errors;
	int lines_run;

	branch_predictor i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.pc(pc),
		.imme_sign(imme_sign),
		.resolve_valid(resolve_valid),
		.resolve_pc(resolve_pc),
		.resolve_taken(resolve_taken),
		.ras_push(ras_push),
		.ras_pop(ras_pop),
		.pc_add_4(pc_add_4),
		.branch_prediction_result(branch_prediction_result),
		.jalr_prediction_result(jalr_prediction_result)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

	task automatic drive_line();
		stall = stall_v;
		pc = pc_v;
		imme_sign = imme_v;
		resolve_valid = valid_v;
		resolve_pc = resolve_pc_v;
		resolve_taken = taken_v;
		ras_push = push_v;
		ras_pop = pop_v;
		pc_add_4 = pc_add_4_v;
	endtask

	// Bit 0 of the check field selects the branch output, bit 1 the jalr output
	task automatic check_outputs(input int line_no);
		if (chk_v[0]) begin
			assert (branch_prediction_result === exp_branch_v) else begin
				value_errors++;
				$display("mismatch branch_prediction_result at line %0d: expected %h, got %h",
					line_no, exp_branch_v, branch_prediction_result);
			end
		end
		if (chk_v[1]) begin
			assert (jalr_prediction_result === exp_jalr_v) else begin
				value_errors++;
				$display("mismatch jalr_prediction_result at line %0d: expected %h, got %h",
					line_no, exp_jalr_v, jalr_prediction_result);
			end
		end
	endtask

	initial begin
		int fd;
		int rc;
		int fields;
		int wait_cycles;
		int line_no;
		string line;
		logic done;

		value_errors = 0;
		format_errors = 0;
		timeout_errors = 0;
		lines_run = 0;
		stall = 1'b0;
		pc = '0;
		imme_sign = 1'b0;
		resolve_valid = 1'b0;
		resolve_pc = '0;
		resolve_taken = 1'b0;
		ras_push = 1'b0;
		ras_pop = 1'b0;
		pc_add_4 = '0;

		wait_cycles = 0;
		while (rst_n !== 1'b1 && wait_cycles < release_timeout) begin
			@(posedge clk);
			wait_cycles++;
		end

		if (rst_n !== 1'b1) begin
			timeout_errors++;
			$display("reset was not released within %0d cycles", release_timeout);
		end else begin
			fd = $fopen(pattern_file, "r");
			if (fd == 0) begin
				format_errors++;
				$display("could not open the pattern file %s", pattern_file);
			end else begin
				done = 1'b0;
				line_no = 0;
				while (!done) begin
					rc = $fgets(line, fd);
					line_no++;
					if (rc == 0) begin
						done = 1'b1;
					end else if (line.len() > 1 && line.getc(0) != "#") begin
						if (lines_run >= max_cycles) begin
							timeout_errors++;
							$display("pattern replay did not finish within %0d cycles",
								max_cycles);
							done = 1'b1;
						end else begin
							fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
								stall_v, pc_v, imme_v, valid_v, resolve_pc_v, taken_v,
								push_v, pop_v, pc_add_4_v, chk_v, exp_branch_v, exp_jalr_v);
							@(negedge clk);
							lines_run++;
							if (fields != 12) begin
								format_errors++;
								$display("pattern line %0d holds %0d of the 12 fields",
									line_no, fields);
							end else begin
								drive_line();
								// Outputs are combinational, settled 1 ns after the edge
								#1;
								check_outputs(line_no);
							end
						end
					end
				end
				$fclose(fd);
			end
		end

		$display("%0d lines run, %0d value errors, %0d format errors, %0d timeouts",
			lines_run, value_errors, format_errors, timeout_errors);
		if (value_errors == 0 && format_errors == 0 && timeout_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire [bp_pkg::pc_width-1:0] pc,
	input wire imme_sign,
	input wire resolve_valid,
	input wire [bp_pkg::pc_width-1:0] resolve_pc,
	input wire resolve_taken,
	input wire ras_push,
	input wire ras_pop,
	input wire [bp_pkg::pc_width-1:0] pc_add_4,
	output logic branch_prediction_result,
	output logic [bp_pkg::pc_width-1:0] jalr_prediction_result
);

	bp_update_if ghp_bus ();
	bp_update_if lhp_bus ();

	bp_ctrl ctrl_inst (
		.clk(clk),
		.rst_n(rst_n),
		.stall(stall),
		.pc(pc),
		.imme_sign(imme_sign),
		.resolve_valid(resolve_valid),
		.resolve_pc(resolve_pc),
		.resolve_taken(resolve_taken),
		.branch_prediction_result(branch_prediction_result),
		.ghp(ghp_bus.ctrl),
		.lhp(lhp_bus.ctrl)
	);

	// Global history
	history_predictor #(
		.hr_width(bp_pkg::ghp_hr_width),
		.index_width(bp_pkg::ghp_index_width),
		.hist_addr_width(bp_pkg::ghp_hist_addr_width)
	) ghp_inst (
		.clk(clk),
		.rst_n(rst_n),
		.bus(ghp_bus.pred)
	);

	// Per-branch local history
	history_predictor #(
		.hr_width(bp_pkg::lhp_hr_width),
		.index_width(bp_pkg::lhp_index_width),
		.hist_addr_width(bp_pkg::lhp_hist_addr_width)
	) lhp_inst (
		.clk(clk),
		.rst_n(rst_n),
		.bus(lhp_bus.pred)
	);

	return_stack ras_inst (
		.clk(clk),
		.rst_n(rst_n),
		.push(ras_push),
		.pop(ras_pop),
		.pc_add_4(pc_add_4),
		.jalr_prediction_result(jalr_prediction_result)
	);

endmodule

`default_nettype wire

/* return_stack.sv */
`timescale 1ns/1ps
`default_nettype none

module return_stack (
	input wire clk,
	input wire rst_n,
	input wire push,
	input wire pop,
	input wire [bp_pkg::pc_width-1:0] pc_add_4,
	output logic [bp_pkg::pc_width-1:0] jalr_prediction_result
);

	localparam int depth = 1 << bp_pkg::ras_addr_width;

	logic [bp_pkg::pc_width-1:0] stack_q [depth];
	logic [bp_pkg::ras_addr_width-1:0] sp_q;
	logic [bp_pkg::ras_addr_width-1:0] sp_inc;
	logic [bp_pkg::ras_addr_width-1:0] sp_dec;

	// Pointer wraps, so the oldest entry is overwritten when full
	assign sp_inc = sp_q + 1'b1;
	assign sp_dec = sp_q - 1'b1;

	assign jalr_prediction_result = stack_q[sp_q];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sp_q <= '0;
			for (int i = 0; i < depth; i++) begin
				stack_q[i] <= '0;
			end
		end else begin
			case ({push, pop})
				2'b10: begin
					stack_q[sp_inc] <= pc_add_4;
					sp_q <= sp_inc;
				end
				2'b01: begin
					sp_q <= sp_dec;
				end
				// Return then call in one cycle, top entry swapped
				2'b11: begin
					stack_q[sp_q] <= pc_add_4;
				end
				default: begin
					sp_q <= sp_q;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* history_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module history_predictor #(
	parameter int hr_width = 6,
	parameter int index_width = 6,
	parameter int hist_addr_width = 0
) (
	input wire clk,
	input wire rst_n,
	bp_update_if.pred bus
);

	localparam int hist_count = 1 << hist_addr_width;
	localparam int sel_width = (hist_addr_width > 0) ? hist_addr_width : 1;
	localparam int table_size = 1 << index_width;

	logic [hr_width-1:0] hist_q [hist_count];
	logic [bp_pkg::counter_width-1:0] counter_q [table_size];
	logic [sel_width-1:0] lookup_sel;
	logic [sel_width-1:0] update_sel;
	logic [index_width-1:0] lookup_hist;
	logic [index_width-1:0] update_hist;
	logic [index_width-1:0] lookup_index;
	logic [index_width-1:0] update_index;
	logic [bp_pkg::counter_width-1:0] update_count;
	logic [bp_pkg::counter_width-1:0] next_count;

	// History register select
	generate
		if (hist_addr_width == 0) begin : g_global
			assign lookup_sel = '0;
			assign update_sel = '0;
		end else begin : g_local
			assign lookup_sel = bus.lookup_pc[hist_addr_width+1:2];
			assign update_sel = bus.update_pc[hist_addr_width+1:2];
		end
	endgenerate

	assign lookup_hist = index_width'(hist_q[lookup_sel]);
	assign update_hist = index_width'(hist_q[update_sel]);

	// gshare style index, word address xor history
	assign lookup_index = bus.lookup_pc[index_width+1:2] ^ lookup_hist;
	assign update_index = bus.update_pc[index_width+1:2] ^ update_hist;

	assign bus.count = counter_q[lookup_index];

	assign update_count = counter_q[update_index];

	always_comb begin
		next_count = update_count;
		if (bus.update_taken) begin
			if (update_count != bp_pkg::counter_max) begin
				next_count = update_count + 1'b1;
			end
		end else if (update_count != '0) begin
			next_count = update_count - 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < table_size; i++) begin
				counter_q[i] <= bp_pkg::counter_init;
			end
			for (int j = 0; j < hist_count; j++) begin
				hist_q[j] <= '0;
			end
		end else if (bus.update_en) begin
			counter_q[update_index] <= next_count;
			// Newest outcome enters at bit 0
			hist_q[update_sel] <= {hist_q[update_sel][hr_width-2:0], bus.update_taken};
		end
	end

endmodule

`default_nettype wire

/* bp_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module bp_ctrl (
	input wire clk,
	input wire rst_n,
	input wire stall,
	input wire [bp_pkg::pc_width-1:0] pc,
	input wire imme_sign,
	input wire resolve_valid,
	input wire [bp_pkg::pc_width-1:0] resolve_pc,
	input wire resolve_taken,
	output logic branch_prediction_result,
	bp_update_if.ctrl ghp,
	bp_update_if.ctrl lhp
);

	localparam int chooser_size = 1 << bp_pkg::chooser_index_width;
	localparam int cmsb = bp_pkg::counter_width - 1;

	logic [bp_pkg::counter_width-1:0] chooser_q [chooser_size];
	logic [bp_pkg::pc_width-1:0] lookup_pc;
	logic update_en;
	logic [bp_pkg::chooser_index_width-1:0] lookup_index;
	logic [bp_pkg::chooser_index_width-1:0] update_index;
	logic [bp_pkg::counter_width-1:0] chooser_count;
	logic [bp_pkg::counter_width-1:0] chooser_next;
	logic [bp_pkg::counter_width-1:0] chosen_count;
	logic ghp_pred;
	logic lhp_pred;
	logic chosen_weak;

	// A resolving branch borrows the lookup path to read its component predictions
	assign lookup_pc = resolve_valid ? resolve_pc : pc;
	assign update_en = resolve_valid && !stall;

	assign ghp.lookup_pc = lookup_pc;
	assign ghp.update_en = update_en;
	assign ghp.update_pc = resolve_pc;
	assign ghp.update_taken = resolve_taken;

	assign lhp.lookup_pc = lookup_pc;
	assign lhp.update_en = update_en;
	assign lhp.update_pc = resolve_pc;
	assign lhp.update_taken = resolve_taken;

	assign ghp_pred = ghp.count[cmsb];
	assign lhp_pred = lhp.count[cmsb];

	assign lookup_index = lookup_pc[bp_pkg::chooser_index_width+1:2];
	assign update_index = resolve_pc[bp_pkg::chooser_index_width+1:2];

	// Chooser msb set means trust the global predictor
	assign chosen_count = chooser_q[lookup_index][cmsb] ? ghp.count : lhp.count;
	assign chosen_weak = (chosen_count == bp_pkg::counter_weak_nt) ||
		(chosen_count == bp_pkg::counter_weak_t);

	// Weak counters fall back to backward taken
	assign branch_prediction_result = chosen_weak ? imme_sign : chosen_count[cmsb];

	assign chooser_count = chooser_q[update_index];

	always_comb begin
		chooser_next = chooser_count;
		if (ghp_pred == resolve_taken) begin
			if (chooser_count != bp_pkg::counter_max) begin
				chooser_next = chooser_count + 1'b1;
			end
		end else if (chooser_count != '0) begin
			chooser_next = chooser_count - 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < chooser_size; i++) begin
				chooser_q[i] <= bp_pkg::counter_init;
			end
		end else if (update_en && (ghp_pred != lhp_pred)) begin
			// Train only when the two predictors disagree
			chooser_q[update_index] <= chooser_next;
		end
	end

endmodule

`default_nettype wire

/* bp_update_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface bp_update_if;

	logic [bp_pkg::pc_width-1:0] lookup_pc;
	logic update_en;
	logic [bp_pkg::pc_width-1:0] update_pc;
	logic update_taken;
	// Counter selected by lookup_pc
	logic [bp_pkg::counter_width-1:0] count;

	modport ctrl (
		output lookup_pc,
		output update_en,
		output update_pc,
		output update_taken,
		input count
	);

	modport pred (
		input lookup_pc,
		input update_en,
		input update_pc,
		input update_taken,
		output count
	);

endinterface

`default_nettype wire

/* bp_pkg.sv */
`default_nettype none

package bp_pkg;

	// Instruction address width
	localparam int pc_width = 32;

	// 2-bit saturating direction counters
	localparam int counter_width = 2;
	localparam logic [counter_width-1:0] counter_init = 2'd1;
	localparam logic [counter_width-1:0] counter_max = 2'd3;
	localparam logic [counter_width-1:0] counter_weak_nt = 2'd1;
	localparam logic [counter_width-1:0] counter_weak_t = 2'd2;

	// Global history predictor, one shared history register
	localparam int ghp_hr_width = 6;
	localparam int ghp_index_width = 6;
	localparam int ghp_hist_addr_width = 0;

	// Local history predictor, 16 history registers
	localparam int lhp_hr_width = 4;
	localparam int lhp_index_width = 5;
	localparam int lhp_hist_addr_width = 4;

	localparam int chooser_index_width = 5;

	// 8-entry return stack
	localparam int ras_addr_width = 3;

endpackage

`default_nettype wire
